// File: hdl/ahb_settings.svh
// AHB peripheral subsystem settings

`ifndef AHB_SETTINGS_SVH
`define AHB_SETTINGS_SVH

//////////////////////////////
// Bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

//////////////////////////////
// Memory map
`define SRAM_DEPTH 512                // Words of SRAM
`define SRAM_BASE  32'h0000_0000
`define SRAM_MASK  32'hE000_0000      // Aliases inside its 512 MB region
`define TIMER_BASE 32'h4000_0000
`define TIMER_MASK 32'hFFFF_FFE0      // 32-byte window, eight word slots

// Implemented timer registers, upper slots read as zero
`define TIMER_REG_NUM 4

//////////////////////////////
// Read-sequence signature
`define SIG_FIRST  32'hDEAD_BEEF      // Must be read first
`define SIG_SECOND 32'hC0DE_CAFE      // Must follow directly

`endif

// File: hdl/ahb_pkg.sv
// AHB-Lite bus types

`include "ahb_settings.svh"

package ahb_pkg;

   // Bus data word
   typedef logic [`AHB_DATA_W-1:0] hdata_t;

   // HTRANS encoding, only NONSEQ and SEQ carry a transfer
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   // Address word, two views of the same bits
   // raw    used by the decoder for base and mask compare
   // fields used by register slaves for the word slot
   typedef union packed {
      logic [`AHB_ADDR_W-1:0] raw;
      struct packed {
         logic [`AHB_ADDR_W-6:0] page;      // Upper bits, window select
         logic [2:0]             reg_idx;   // Word slot in a 32-byte window
         logic [1:0]             byte_lane; // Always zero for word transfers
      } fields;
   } haddr_u;

endpackage

// File: hdl/soc_map_pkg.sv
// Subsystem memory map types

`include "ahb_settings.svh"

package soc_map_pkg;

   // Word index into the SRAM, taken from address bits 10 to 2
   typedef logic [$clog2(`SRAM_DEPTH)-1:0] sram_idx_t;

   // Slave owning the current data phase
   typedef enum logic [1:0] {
      SLV_NONE,   // Unmapped, reads zero
      SLV_SRAM,
      SLV_TIMER
   } slave_e;

   // Timer register slots
   typedef enum logic [2:0] {
      TMR_CTRL    = 3'd0,  // Bit 0 enable, bit 1 irq enable
      TMR_COMPARE = 3'd1,  // Compare value
      TMR_COUNT   = 3'd2,  // Free counter
      TMR_STATUS  = 3'd3   // Bit 0 pending, write 1 clears
   } timer_reg_e;

endpackage

// File: hdl/ahb_slave_if.sv
// Decoder to slave link

`timescale 1ns/10ps

interface ahb_slave_if;
   import ahb_pkg::*;

   logic   sel;    // Valid transfer hits this slave, address phase
   haddr_u addr;   // Address phase
   logic   write;  // Address phase
   hdata_t wdata;  // Data phase
   hdata_t rdata;  // Data phase, registered by the slave

   // Decoder side
   modport decoder (
      output sel, addr, write, wdata,
      input  rdata
   );

   // Slave side
   modport slave (
      input  sel, addr, write, wdata,
      output rdata
   );

endinterface

// File: hdl/ahb_decoder.sv
// AHB-Lite address decoder and read mux

`timescale 1ns/10ps
`include "ahb_settings.svh"

module ahb_decoder (
   input  logic                   hclk_i,
   input  logic                   reset_i,
   input  ahb_pkg::htrans_e       htrans_i,
   input  ahb_pkg::haddr_u        haddr_i,
   input  logic                   hwrite_i,
   input  logic [`AHB_DATA_W-1:0] hwdata_i,
   output logic [`AHB_DATA_W-1:0] hrdata_o,
   output logic                   rd_valid_o,  // Completed read, data phase
   output logic [`AHB_DATA_W-1:0] rd_data_o,
   ahb_slave_if.decoder           sram_bus,
   ahb_slave_if.decoder           timer_bus
);
   import ahb_pkg::*;
   import soc_map_pkg::*;

   logic   trans_valid;
   logic   sram_hit;
   logic   timer_hit;
   slave_e slave_d;
   slave_e slave_q;     // Owner of the data phase
   logic   rd_valid_q;

   //////////////////////////////
   // Address phase

   assign trans_valid = (htrans_i == NONSEQ) || (htrans_i == SEQ);   // IDLE and BUSY ignored

   assign sram_hit  = ((haddr_i.raw & `SRAM_MASK) == `SRAM_BASE);
   assign timer_hit = ((haddr_i.raw & `TIMER_MASK) == `TIMER_BASE);

   // Both slaves see the same address and write data
   assign sram_bus.sel    = trans_valid && sram_hit;
   assign sram_bus.addr   = haddr_i;
   assign sram_bus.write  = hwrite_i;
   assign sram_bus.wdata  = hwdata_i;   // Belongs to the previous address phase

   assign timer_bus.sel   = trans_valid && timer_hit;
   assign timer_bus.addr  = haddr_i;
   assign timer_bus.write = hwrite_i;
   assign timer_bus.wdata = hwdata_i;

   always_comb begin
      slave_d = SLV_NONE;                        // Unmapped or no transfer
      if (sram_bus.sel) begin
         slave_d = SLV_SRAM;
      end else if (timer_bus.sel) begin
         slave_d = SLV_TIMER;
      end
   end

   // Carry owner and read flag into the data phase
   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         slave_q    <= SLV_NONE;
         rd_valid_q <= 1'b0;
      end else begin
         slave_q    <= slave_d;
         rd_valid_q <= trans_valid && !hwrite_i; // Unmapped reads count too
      end
   end

   //////////////////////////////
   // Data phase

   always_comb begin
      case (slave_q)
         SLV_SRAM:  hrdata_o = sram_bus.rdata;
         SLV_TIMER: hrdata_o = timer_bus.rdata;
         default:   hrdata_o = '0;               // Unmapped reads as zero
      endcase
   end

   assign rd_valid_o = rd_valid_q;
   assign rd_data_o  = hrdata_o;                 // Same word the master sees

endmodule

// File: hdl/ahb_sram.sv
// Zero-wait-state SRAM slave

`timescale 1ns/10ps
`include "ahb_settings.svh"

module ahb_sram (
   input  logic       hclk_i,
   input  logic       reset_i,
   ahb_slave_if.slave bus
);
   import ahb_pkg::*;
   import soc_map_pkg::*;

   localparam int IDX_W = $bits(sram_idx_t);

   hdata_t    mem [`SRAM_DEPTH];
   sram_idx_t idx;          // Address-phase word index
   sram_idx_t wr_idx_q;     // Word index of the write in data phase
   logic      wr_pend_q;    // Write in data phase
   logic      fwd_hit;
   hdata_t    rdata_q;

   // Bits 10 to 2, higher bits alias
   assign idx = bus.addr.raw[IDX_W+1:2];

   // Previous transfer writes the word being read now
   assign fwd_hit = wr_pend_q && (wr_idx_q == idx);

   //////////////////////////////
   // Write path

   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         wr_pend_q <= 1'b0;
      end else begin
         wr_pend_q <= bus.sel && bus.write;  // Latch at end of address phase
      end
   end

   always_ff @(posedge hclk_i) begin
      if (bus.sel && bus.write) begin
         wr_idx_q <= idx;
      end
      if (wr_pend_q) begin
         mem[wr_idx_q] <= bus.wdata;          // End of data phase
      end
   end

   //////////////////////////////
   // Read path

   always_ff @(posedge hclk_i) begin
      if (bus.sel && !bus.write) begin
         // Memory still holds the old word at this edge
         rdata_q <= fwd_hit ? bus.wdata : mem[idx];
      end
   end

   assign bus.rdata = rdata_q;  // Stable through the data phase

endmodule

// File: hdl/ahb_timer.sv
// Compare timer slave with interrupt

`timescale 1ns/10ps
`include "ahb_settings.svh"

module ahb_timer (
   input  logic       hclk_i,
   input  logic       reset_i,
   ahb_slave_if.slave bus,
   output logic       irq_o
);
   import ahb_pkg::*;
   import soc_map_pkg::*;

   timer_reg_e rd_reg;       // Address-phase slot
   logic       reg_ok;       // Slot is implemented
   hdata_t     rd_word;
   hdata_t     rdata_q;

   logic       wr_pend_q;    // Register write in data phase
   timer_reg_e wr_reg_q;
   logic       wr_ctrl;
   logic       wr_compare;
   logic       wr_count;
   logic       wr_clear;

   logic       en_q;         // CTRL bit 0
   logic       ie_q;         // CTRL bit 1
   hdata_t     compare_q;
   hdata_t     count_q;
   logic       pending_q;
   logic       irq_q;
   logic       match;

   assign rd_reg = timer_reg_e'(bus.addr.fields.reg_idx);
   assign reg_ok = bus.addr.fields.reg_idx < 3'(`TIMER_REG_NUM);

   //////////////////////////////
   // Register read

   always_comb begin
      rd_word = '0;             // Unused slots read zero
      if (reg_ok) begin
         case (rd_reg)
            TMR_CTRL:    rd_word = {{(`AHB_DATA_W-2){1'b0}}, ie_q, en_q};
            TMR_COMPARE: rd_word = compare_q;
            TMR_COUNT:   rd_word = count_q;
            TMR_STATUS:  rd_word = {{(`AHB_DATA_W-1){1'b0}}, pending_q};
            default:     rd_word = '0;
         endcase
      end
   end

   always_ff @(posedge hclk_i) begin
      if (bus.sel && !bus.write) begin
         rdata_q <= rd_word;    // Sampled at end of address phase
      end
   end

   assign bus.rdata = rdata_q;

   //////////////////////////////
   // Register write and counter

   // Data-phase write strobes
   assign wr_ctrl    = wr_pend_q && (wr_reg_q == TMR_CTRL);
   assign wr_compare = wr_pend_q && (wr_reg_q == TMR_COMPARE);
   assign wr_count   = wr_pend_q && (wr_reg_q == TMR_COUNT);
   assign wr_clear   = wr_pend_q && (wr_reg_q == TMR_STATUS) && bus.wdata[0];

   assign match = en_q && (count_q == compare_q);

   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         wr_pend_q <= 1'b0;
         wr_reg_q  <= TMR_CTRL;
         en_q      <= 1'b0;
         ie_q      <= 1'b0;
         compare_q <= '0;
         count_q   <= '0;
         pending_q <= 1'b0;
         irq_q     <= 1'b0;
      end else begin
         wr_pend_q <= bus.sel && bus.write && reg_ok;
         wr_reg_q  <= rd_reg;
         if (wr_ctrl) begin
            en_q <= bus.wdata[0];
            ie_q <= bus.wdata[1];
         end
         if (wr_compare) compare_q <= bus.wdata;
         if (wr_count) begin
            count_q <= bus.wdata;       // Software load wins
         end else if (match) begin
            count_q <= '0;              // Wrap on compare
         end else if (en_q) begin
            count_q <= count_q + 1'b1;
         end
         if (match) begin
            pending_q <= 1'b1;          // Match beats a clear in the same cycle
         end else if (wr_clear) begin
            pending_q <= 1'b0;
         end
         irq_q <= pending_q && ie_q;    // One cycle behind pending
      end
   end

   assign irq_o = irq_q;

endmodule

// File: hdl/read_sequence_detector.sv
// Signature read-sequence detector

`timescale 1ns/10ps
`include "ahb_settings.svh"

module read_sequence_detector (
   input  logic                   hclk_i,
   input  logic                   reset_i,
   input  logic                   rd_valid_i,  // Completed read
   input  logic [`AHB_DATA_W-1:0] rd_data_i,
   output logic                   detected_o
);

   typedef enum logic [1:0] {
      ST_FIRST,    // Waiting for SIG_FIRST
      ST_SECOND,   // SIG_FIRST seen, next read must be SIG_SECOND
      ST_FOUND     // Sticky until reset
   } state_e;

   state_e state_d;
   state_e state_q;

   always_comb begin
      state_d = state_q;   // Idle cycles and writes keep the state
      if (rd_valid_i) begin
         case (state_q)
            ST_FIRST: begin
               if (rd_data_i == `SIG_FIRST) state_d = ST_SECOND;
            end
            ST_SECOND: begin
               if (rd_data_i == `SIG_SECOND) begin
                  state_d = ST_FOUND;
               end else if (rd_data_i == `SIG_FIRST) begin
                  state_d = ST_SECOND;   // Breaking read can start a new sequence
               end else begin
                  state_d = ST_FIRST;
               end
            end
            default: state_d = ST_FOUND;
         endcase
      end
   end

   always_ff @(posedge hclk_i) begin
      if (reset_i) state_q <= ST_FIRST;
      else         state_q <= state_d;
   end

   assign detected_o = (state_q == ST_FOUND);   // Rises after the second data phase

endmodule

// File: hdl/ahb_periph_top.sv
// AHB-Lite peripheral subsystem top

`timescale 1ns/10ps
`include "ahb_settings.svh"

module ahb_periph_top (
   input  logic                   hclk_i,
   input  logic                   reset_i,
   input  ahb_pkg::htrans_e       htrans_i,
   input  logic [`AHB_ADDR_W-1:0] haddr_i,
   input  logic                   hwrite_i,
   input  logic [`AHB_DATA_W-1:0] hwdata_i,
   output logic [`AHB_DATA_W-1:0] hrdata_o,
   output logic                   irq_o,       // Timer interrupt
   output logic                   detected_o   // Signature sequence seen
);

   logic                   rd_valid;
   logic [`AHB_DATA_W-1:0] rd_data;

   //////////////////////////////
   // Slave links

   ahb_slave_if sram_bus ();
   ahb_slave_if timer_bus ();

   //////////////////////////////
   // Instances

   ahb_decoder inst_decoder (
      .hclk_i     ( hclk_i     ),
      .reset_i    ( reset_i    ),
      .htrans_i   ( htrans_i   ),
      .haddr_i    ( haddr_i    ),   // Raw word into the address union
      .hwrite_i   ( hwrite_i   ),
      .hwdata_i   ( hwdata_i   ),
      .hrdata_o   ( hrdata_o   ),
      .rd_valid_o ( rd_valid   ),
      .rd_data_o  ( rd_data    ),
      .sram_bus   ( sram_bus   ),
      .timer_bus  ( timer_bus  )
   );

   ahb_sram inst_sram (
      .hclk_i     ( hclk_i     ),
      .reset_i    ( reset_i    ),
      .bus        ( sram_bus   )
   );

   ahb_timer inst_timer (
      .hclk_i     ( hclk_i     ),
      .reset_i    ( reset_i    ),
      .bus        ( timer_bus  ),
      .irq_o      ( irq_o      )
   );

   read_sequence_detector inst_detector (
      .hclk_i     ( hclk_i     ),
      .reset_i    ( reset_i    ),
      .rd_valid_i ( rd_valid   ),   // Fed by completed bus reads
      .rd_data_i  ( rd_data    ),
      .detected_o ( detected_o )
   );

endmodule

// File: verif/tb_ahb_periph.sv
// AHB-Lite peripheral subsystem testbench

`timescale 1ns/10ps
`include "ahb_settings.svh"

module tb_ahb_periph;
   import ahb_pkg::*;

   localparam int PERIOD = 100;

   // Cycle budget of each test for the watchdog
   localparam int RESET_CYCLES  = 10;
   localparam int SRAM_BUDGET   = 80;
   localparam int FWD_BUDGET    = 20;
   localparam int UNMAP_BUDGET  = 30;
   localparam int TIMER_BUDGET  = 200;
   localparam int DETECT_BUDGET = 100;
   localparam int TOTAL_BUDGET  = 2 * RESET_CYCLES + SRAM_BUDGET + FWD_BUDGET
                                  + UNMAP_BUDGET + TIMER_BUDGET + DETECT_BUDGET;

   // Detector test words
   localparam logic [31:0] SIG1_ADDR    = 32'h0000_0100;
   localparam logic [31:0] SIG2_ADDR    = 32'h0000_0104;
   localparam logic [31:0] OTHER_ADDR   = 32'h0000_0108;
   localparam logic [31:0] SCRATCH_ADDR = 32'h0000_010C;

   logic        hclk_i;
   logic        reset_i;
   htrans_e     htrans_i;
   logic [31:0] haddr_i;
   logic        hwrite_i;
   logic [31:0] hwdata_i;
   logic [31:0] hrdata_o;
   logic        irq_o;
   logic        detected_o;

   int seed = 72;
   int error_count = 0;
   int check_count = 0;
   int test_count = 0;
   int test_start_errors = 0;

   // Pending transfers and collected read data
   bit          q_write [$];
   logic [31:0] q_addr  [$];
   logic [31:0] q_wdata [$];
   logic [31:0] q_rdata [$];

   ahb_periph_top uut (
      .hclk_i     ( hclk_i     ),
      .reset_i    ( reset_i    ),
      .htrans_i   ( htrans_i   ),
      .haddr_i    ( haddr_i    ),
      .hwrite_i   ( hwrite_i   ),
      .hwdata_i   ( hwdata_i   ),
      .hrdata_o   ( hrdata_o   ),
      .irq_o      ( irq_o      ),
      .detected_o ( detected_o )
   );

   initial begin
      hclk_i = 1'b0;
      forever #(PERIOD / 2) hclk_i = ~hclk_i;
   end

   //////////////////////////////
   // Bus helpers

   function automatic logic [31:0] timer_addr(input logic [2:0] slot);
      return `TIMER_BASE | {27'd0, slot, 2'b00};   // Word slot in the timer window
   endfunction

   task automatic apply_reset();
      reset_i  = 1'b1;
      htrans_i = IDLE;
      hwrite_i = 1'b0;
      repeat (RESET_CYCLES) @(negedge hclk_i);
      reset_i = 1'b0;
   endtask

   task automatic queue_write(input logic [31:0] addr, input logic [31:0] data);
      q_addr.push_back(addr);
      q_write.push_back(1'b1);
      q_wdata.push_back(data);
   endtask

   task automatic queue_read(input logic [31:0] addr);
      q_addr.push_back(addr);
      q_write.push_back(1'b0);
      q_wdata.push_back(32'h0);   // Bus data unused by reads
   endtask

   // Issues the queued transfers back to back with overlapping phases
   task automatic run_bus();
      int n;
      n = q_addr.size();
      q_rdata.delete();
      for (int i = 0; i <= n; i++) begin
         @(negedge hclk_i);
         if (i > 0) begin
            if (!q_write[i-1]) q_rdata.push_back(hrdata_o);   // Mid data phase
            hwdata_i = q_wdata[i-1];
         end
         if (i < n) begin
            htrans_i = NONSEQ;
            haddr_i  = q_addr[i];
            hwrite_i = q_write[i];
         end else begin
            htrans_i = IDLE;        // Last data phase only
            hwrite_i = 1'b0;
         end
      end
      q_addr.delete();
      q_write.delete();
      q_wdata.delete();
   endtask

   task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
      queue_write(addr, data);
      run_bus();
   endtask

   task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
      queue_read(addr);
      run_bus();
      data = q_rdata.pop_front();
   endtask

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         $display("Error in %s: expected %h, actual %h", test_name, expected, actual);
         error_count++;
      end
   endtask

   task automatic report_test(input string test_name);
      test_count++;
      $display("Test %s finished with %0d errors", test_name,
               error_count - test_start_errors);
   endtask

   //////////////////////////////
   // Directed tests

   task automatic test_sram_round_trip();
      logic [31:0] addr_list [16];
      logic [31:0] model [`SRAM_DEPTH];
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] got;
      test_start_errors = error_count;
      for (int i = 0; i < 16; i++) begin
         addr = $random(seed) & 32'h1FFF_FFFC;   // Anywhere in the SRAM region
         data = $random(seed);
         addr_list[i] = addr;
         model[addr[10:2]] = data;               // Last write per word wins
         queue_write(addr, data);
      end
      run_bus();
      for (int i = 0; i < 16; i++) begin
         // Same word through another alias
         addr = ($random(seed) & 32'h1FFF_F800) | (addr_list[i] & 32'h0000_07FC);
         queue_read(addr);
      end
      run_bus();
      for (int i = 0; i < 16; i++) begin
         got = q_rdata.pop_front();
         check_value("sram_round_trip", model[addr_list[i][10:2]], got);
      end
      report_test("sram_round_trip");
   endtask

   task automatic test_forwarding();
      logic [31:0] got;
      test_start_errors = error_count;
      queue_write(32'h0000_0040, 32'h1111_2222);
      queue_read(32'h0000_0040);
      queue_write(32'h0000_0040, 32'h3333_4444);
      queue_read(32'h0200_0040);                 // Alias of the same word
      run_bus();
      got = q_rdata.pop_front();
      check_value("forwarding", 32'h1111_2222, got);
      got = q_rdata.pop_front();
      check_value("forwarding", 32'h3333_4444, got);
      report_test("forwarding");
   endtask

   task automatic test_unmapped();
      logic [31:0] got;
      test_start_errors = error_count;
      write_word(32'h0000_0000, 32'h5A5A_A5A5);
      write_word(32'h8000_0000, 32'hFFFF_0000);   // Hole in the map
      read_word(32'h8000_0000, got);
      check_value("unmapped", 32'h0, got);
      read_word(32'h0000_0000, got);             // SRAM word 0 untouched
      check_value("unmapped", 32'h5A5A_A5A5, got);
      write_word(timer_addr(3'd5), 32'hFFFF_FFFF);
      read_word(timer_addr(3'd5), got);          // Unused timer slot
      check_value("unmapped", 32'h0, got);
      report_test("unmapped");
   endtask

   task automatic test_timer_irq();
      logic [31:0] got;
      int waited;
      test_start_errors = error_count;
      write_word(timer_addr(soc_map_pkg::TMR_COMPARE), 32'd20);
      write_word(timer_addr(soc_map_pkg::TMR_CTRL), 32'h3);   // Enable and irq enable
      waited = 0;
      while (irq_o !== 1'b1 && waited < 30) begin
         @(negedge hclk_i);
         waited++;
      end
      if (irq_o !== 1'b1) begin
         $display("timer_irq: irq_o did not rise within 30 cycles");
         error_count++;
      end
      write_word(timer_addr(soc_map_pkg::TMR_STATUS), 32'h1);  // Clear pending
      waited = 0;
      while (irq_o !== 1'b0 && waited < 3) begin
         @(negedge hclk_i);
         waited++;
      end
      if (irq_o !== 1'b0) begin
         $display("timer_irq: irq_o did not drop within 3 cycles of the clear");
         error_count++;
      end
      write_word(timer_addr(soc_map_pkg::TMR_CTRL), 32'h1);   // Count on with irq masked
      repeat (60) begin
         @(negedge hclk_i);
         check_value("timer_irq", 32'h0, irq_o);
      end
      read_word(timer_addr(soc_map_pkg::TMR_STATUS), got);
      check_value("timer_irq", 32'h1, got);     // Matches still set pending
      write_word(timer_addr(soc_map_pkg::TMR_CTRL), 32'h0);
      report_test("timer_irq");
   endtask

   task automatic test_detector();
      test_start_errors = error_count;
      queue_write(SIG1_ADDR, `SIG_FIRST);
      queue_write(SIG2_ADDR, `SIG_SECOND);
      queue_write(OTHER_ADDR, 32'h1234_5678);
      run_bus();
      // Wrong order
      queue_read(SIG2_ADDR);
      queue_read(SIG1_ADDR);
      run_bus();
      @(negedge hclk_i);
      check_value("detector", 32'h0, detected_o);
      // Another read breaks the pair
      queue_read(SIG1_ADDR);
      queue_read(OTHER_ADDR);
      queue_read(SIG2_ADDR);
      run_bus();
      @(negedge hclk_i);
      check_value("detector", 32'h0, detected_o);
      // Consecutive reads with a write between them
      queue_read(SIG1_ADDR);
      queue_write(SCRATCH_ADDR, 32'h0);
      queue_read(SIG2_ADDR);
      run_bus();
      @(negedge hclk_i);                         // One cycle after the second data phase
      check_value("detector", 32'h1, detected_o);
      queue_read(OTHER_ADDR);
      queue_read(SIG2_ADDR);
      queue_read(SIG1_ADDR);
      run_bus();
      @(negedge hclk_i);
      check_value("detector", 32'h1, detected_o);   // Sticky
      // Unmask the timer match still pending
      write_word(timer_addr(soc_map_pkg::TMR_CTRL), 32'h2);
      repeat (2) @(negedge hclk_i);
      check_value("detector", 32'h1, irq_o);
      // Reset while a read of a nonzero word is on the bus
      htrans_i = NONSEQ;
      haddr_i  = SIG1_ADDR;
      hwrite_i = 1'b0;
      reset_i  = 1'b1;
      repeat (RESET_CYCLES) @(negedge hclk_i);
      check_value("detector", 32'h0, detected_o);
      check_value("detector", 32'h0, irq_o);
      check_value("detector", 32'h0, hrdata_o);
      htrans_i = IDLE;
      reset_i  = 1'b0;
      report_test("detector");
   endtask

   //////////////////////////////
   // Main sequence and watchdog

   initial begin
      reset_i  = 1'b1;
      htrans_i = IDLE;
      haddr_i  = 32'h0;
      hwrite_i = 1'b0;
      hwdata_i = 32'h0;
      apply_reset();
      test_sram_round_trip();
      test_forwarding();
      test_unmapped();
      test_timer_irq();
      test_detector();
      $display("Summary: %0d tests, %0d checks, %0d errors",
               test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      #(TOTAL_BUDGET * 2 * PERIOD);
      $display("Watchdog: the tests did not finish in the expected time");
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: flist.f
+incdir+hdl
hdl/ahb_pkg.sv
hdl/soc_map_pkg.sv
hdl/ahb_slave_if.sv
hdl/ahb_decoder.sv
hdl/ahb_sram.sv
hdl/ahb_timer.sv
hdl/read_sequence_detector.sv
hdl/ahb_periph_top.sv
verif/tb_ahb_periph.sv

// File: Bender.yml
package:
  name: ahb_periph

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ahb_pkg.sv
      - hdl/soc_map_pkg.sv
      - hdl/ahb_slave_if.sv
      - hdl/ahb_decoder.sv
      - hdl/ahb_sram.sv
      - hdl/ahb_timer.sv
      - hdl/read_sequence_detector.sv
      - hdl/ahb_periph_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_ahb_periph.sv
